// ==== kbd_pkg.sv ====
// shared types for the keyboard-to-console path
// stage structs, fsm state enums, fixed set-2 key codes

package kbd_pkg;

   // ====================
   // stage structs
   // ====================

   // one received ps/2 byte
   typedef struct packed {
      logic       valid;
      // bad start, parity or stop bit
      logic       err;
      logic [7:0] data;
   } ps2_frame_t;

   // one decoded key event
   typedef struct packed {
      logic       valid;
      // break (F0) seen before the code
      logic       released;
      // E0 prefix seen before the code
      logic       extended;
      logic [7:0] code;
   } key_event_t;

   // one character bound for the console
   typedef struct packed {
      logic       valid;
      logic [7:0] ascii;
   } char_t;

   // ====================
   // fsm states
   // ====================

   // frame receiver
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_BITS,
      RX_DONE
   } rx_state_e;

   // prefix tracking in the scan code decoder
   typedef enum logic [1:0] {
      DEC_IDLE,
      DEC_BREAK,
      DEC_EXT,
      DEC_EXT_BREAK
   } dec_state_e;

   // ====================
   // fixed scan codes
   // ====================
   localparam logic [7:0] SC_BREAK  = 8'hF0;
   localparam logic [7:0] SC_EXT    = 8'hE0;
   localparam logic [7:0] SC_LSHIFT = 8'h12;
   localparam logic [7:0] SC_RSHIFT = 8'h59;

endpackage

// ==== ps2_frame_rx.sv ====
// ps/2 frame receiver
// pin synchronizers, falling-edge detect, 11-bit shift, frame checks, stall timeout

module ps2_frame_rx import kbd_pkg::*; #(
   parameter int RX_TIMEOUT = 50000
) (
   input  logic       CLOCK_50,
   input  logic       rst_n,
   input  logic       ps2_clk,
   input  logic       ps2_dat,
   output ps2_frame_t frame
);

   localparam int TW = $clog2(RX_TIMEOUT + 1);

   // ====================
   // pin synchronizers
   // ====================
   logic clk_meta;
   logic clk_sync;
   // third flop, only for edge detect
   logic clk_prev;
   logic dat_meta;
   logic dat_sync;
   logic clk_fall;

   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         // ps/2 lines idle high
         clk_meta <= 1'b1;
         clk_sync <= 1'b1;
         clk_prev <= 1'b1;
         dat_meta <= 1'b1;
         dat_sync <= 1'b1;
      end else begin
         clk_meta <= ps2_clk;
         clk_sync <= clk_meta;
         clk_prev <= clk_sync;
         dat_meta <= ps2_dat;
         dat_sync <= dat_meta;
      end
   end

   // data is sampled on the falling ps/2 clock
   assign clk_fall = clk_prev & ~clk_sync;

   // ====================
   // frame fsm
   // ====================
   rx_state_e      state;
   logic [3:0]     bit_cnt;
   // start at [0], data [8:1], parity [9], stop [10]
   logic [10:0]    shift;
   logic [TW-1:0]  idle_cnt;
   logic           bad_start;
   logic           bad_parity;
   logic           bad_stop;

   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         state    <= RX_IDLE;
         bit_cnt  <= '0;
         idle_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               idle_cnt <= '0;
               if (clk_fall) begin
                  // start bit taken here
                  bit_cnt <= 4'd1;
                  state   <= RX_BITS;
               end
            end
            RX_BITS: begin
               if (clk_fall) begin
                  idle_cnt <= '0;
                  bit_cnt  <= bit_cnt + 4'd1;
                  // eleventh bit sampled now
                  if (bit_cnt == 4'd10) begin
                     state <= RX_DONE;
                  end
               end else if (idle_cnt == TW'(RX_TIMEOUT - 1)) begin
                  // keyboard stalled so the partial frame is dropped
                  state <= RX_IDLE;
               end else begin
                  idle_cnt <= idle_cnt + 1'b1;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // frame shift register
   always_ff @(posedge CLOCK_50) begin
      if (clk_fall && state != RX_DONE) begin
         // lsb first so new bits enter at the top
         shift <= {dat_sync, shift[10:1]};
      end
   end

   // frame checks
   assign bad_start  = shift[0];
   assign bad_parity = ~(^shift[9:1]);
   assign bad_stop   = ~shift[10];

   // ====================
   // output register
   // ====================
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         frame.valid <= 1'b0;
      end else begin
         // strobe one cycle after the stop bit
         frame.valid <= (state == RX_DONE);
         frame.err   <= bad_start | bad_parity | bad_stop;
         frame.data  <= shift[8:1];
      end
   end

endmodule

// ==== scan_code_decoder.sv ====
// set-2 scan code decoder
// break/extended prefix tracking, one key event per complete sequence

module scan_code_decoder import kbd_pkg::*; (
   input  logic       CLOCK_50,
   input  logic       rst_n,
   input  ps2_frame_t frame,
   output key_event_t key_event
);

   dec_state_e state;
   logic       is_release;
   logic       is_ext;

   // flags for the code that ends the sequence
   assign is_release = (state == DEC_BREAK) || (state == DEC_EXT_BREAK);
   assign is_ext     = (state == DEC_EXT) || (state == DEC_EXT_BREAK);

   // ====================
   // prefix fsm
   // ====================
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         state <= DEC_IDLE;
      end else if (frame.valid) begin
         if (frame.err) begin
            // corrupt byte, forget any pending prefix
            state <= DEC_IDLE;
         end else begin
            case (frame.data)
               SC_EXT: begin
                  state <= DEC_EXT;
               end
               SC_BREAK: begin
                  // F0 after E0 keeps the extended flag
                  if (is_ext) begin
                     state <= DEC_EXT_BREAK;
                  end else begin
                     state <= DEC_BREAK;
                  end
               end
               default: begin
                  // plain code closes the sequence
                  state <= DEC_IDLE;
               end
            endcase
         end
      end
   end

   // ====================
   // event register
   // ====================
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         key_event.valid <= 1'b0;
      end else begin
         // prefixes and bad frames give no event
         // a repeated make code gives a new press each time
         key_event.valid    <= frame.valid && !frame.err &&
                               (frame.data != SC_EXT) && (frame.data != SC_BREAK);
         key_event.released <= is_release;
         key_event.extended <= is_ext;
         key_event.code     <= frame.data;
      end
   end

endmodule

// ==== ascii_mapper.sv ====
// key event to ascii translation
// shift tracking and set-2 make code lookup

module ascii_mapper import kbd_pkg::*; (
   input  logic       CLOCK_50,
   input  logic       rst_n,
   input  key_event_t key_event,
   output char_t      char
);

   logic  lshift;
   logic  rshift;
   char_t mapped;

   // ====================
   // code table
   // ====================
   // valid field means the code has a mapping
   function automatic char_t map_code(input logic [7:0] code, input logic upper);
      char_t      res;
      logic       letter;
      res    = '0;
      letter = 1'b1;
      case (code)
         8'h1C: res.ascii = "a";
         8'h32: res.ascii = "b";
         8'h21: res.ascii = "c";
         8'h23: res.ascii = "d";
         8'h24: res.ascii = "e";
         8'h2B: res.ascii = "f";
         8'h34: res.ascii = "g";
         8'h33: res.ascii = "h";
         8'h43: res.ascii = "i";
         8'h3B: res.ascii = "j";
         8'h42: res.ascii = "k";
         8'h4B: res.ascii = "l";
         8'h3A: res.ascii = "m";
         8'h31: res.ascii = "n";
         8'h44: res.ascii = "o";
         8'h4D: res.ascii = "p";
         8'h15: res.ascii = "q";
         8'h2D: res.ascii = "r";
         8'h1B: res.ascii = "s";
         8'h2C: res.ascii = "t";
         8'h3C: res.ascii = "u";
         8'h2A: res.ascii = "v";
         8'h1D: res.ascii = "w";
         8'h22: res.ascii = "x";
         8'h35: res.ascii = "y";
         8'h1A: res.ascii = "z";
         default: letter = 1'b0;
      endcase
      if (letter) begin
         res.valid = 1'b1;
         // upper case is 20h below lower case
         if (upper) begin
            res.ascii = res.ascii - 8'h20;
         end
      end else begin
         // digits and controls ignore shift
         res.valid = 1'b1;
         case (code)
            8'h45: res.ascii = "0";
            8'h16: res.ascii = "1";
            8'h1E: res.ascii = "2";
            8'h26: res.ascii = "3";
            8'h25: res.ascii = "4";
            8'h2E: res.ascii = "5";
            8'h36: res.ascii = "6";
            8'h3D: res.ascii = "7";
            8'h3E: res.ascii = "8";
            8'h46: res.ascii = "9";
            8'h29: res.ascii = 8'h20;
            8'h5A: res.ascii = 8'h0D;
            8'h66: res.ascii = 8'h08;
            default: res.valid = 1'b0;
         endcase
      end
      return res;
   endfunction

   assign mapped = map_code(key_event.code, lshift | rshift);

   // ====================
   // shift flags
   // ====================
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         lshift <= 1'b0;
         rshift <= 1'b0;
      end else if (key_event.valid && !key_event.extended) begin
         if (key_event.code == SC_LSHIFT) begin
            lshift <= !key_event.released;
         end
         if (key_event.code == SC_RSHIFT) begin
            rshift <= !key_event.released;
         end
      end
   end

   // output only for plain presses with a mapping
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         char.valid <= 1'b0;
      end else begin
         char.valid <= key_event.valid && !key_event.extended &&
                       !key_event.released && mapped.valid;
         char.ascii <= mapped.ascii;
      end
   end

endmodule

// ==== char_write_port.sv ====
// console write strobe and board leds
// last-char leds, sticky error led, heartbeat

module char_write_port import kbd_pkg::*; #(
   parameter int HEARTBEAT_DIV = 25000000
) (
   input  logic        CLOCK_50,
   input  logic        rst_n,
   input  char_t       char,
   input  logic        frame_err,
   output logic        avalon_write,
   output logic [31:0] avalon_writedata,
   output logic [7:0]  leds_green,
   output logic        led_heartbeat,
   output logic        led_error
);

   localparam int HW = $clog2(HEARTBEAT_DIV + 1);

   logic [HW-1:0] hb_cnt;

   // ====================
   // console write
   // ====================
   // one-cycle strobe, no wait request on this port
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         avalon_write <= 1'b0;
         leds_green   <= 8'h00;
      end else begin
         avalon_write <= char.valid;
         if (char.valid) begin
            avalon_writedata <= {24'h000000, char.ascii};
            leds_green       <= char.ascii;
         end
      end
   end

   // ====================
   // status leds
   // ====================
   always_ff @(posedge CLOCK_50) begin
      if (!rst_n) begin
         led_error     <= 1'b0;
         led_heartbeat <= 1'b0;
         hb_cnt        <= '0;
      end else begin
         // sticky until reset
         if (frame_err) begin
            led_error <= 1'b1;
         end
         if (hb_cnt == HW'(HEARTBEAT_DIV - 1)) begin
            hb_cnt        <= '0;
            led_heartbeat <= ~led_heartbeat;
         end else begin
            hb_cnt <= hb_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== kbd_console_top.sv ====
// board top level for the keyboard-to-console path
// chains receiver, decoder, mapper and write port

module kbd_console_top import kbd_pkg::*; #(
   // ~1 ms without a ps/2 clock edge at 50 MHz
   parameter int RX_TIMEOUT    = 50000,
   // toggle every 0.5 s
   parameter int HEARTBEAT_DIV = 25000000
) (
   input  logic        CLOCK_50,
   input  logic        rst_n,
   input  logic        ps2_clk,
   input  logic        ps2_dat,
   output logic        avalon_write,
   output logic        avalon_address,
   output logic [31:0] avalon_writedata,
   output logic [7:0]  leds_green,
   output logic        led_heartbeat,
   output logic        led_error
);

   ps2_frame_t frame;
   key_event_t key_event;
   char_t      char;
   logic       frame_err;

   // ====================
   // pipeline stages
   // ====================
   ps2_frame_rx #(
      .RX_TIMEOUT(RX_TIMEOUT)
   ) u_rx (
      .CLOCK_50(CLOCK_50),
      .rst_n   (rst_n),
      .ps2_clk (ps2_clk),
      .ps2_dat (ps2_dat),
      .frame   (frame)
   );

   scan_code_decoder u_dec (
      .CLOCK_50 (CLOCK_50),
      .rst_n    (rst_n),
      .frame    (frame),
      .key_event(key_event)
   );

   ascii_mapper u_map (
      .CLOCK_50 (CLOCK_50),
      .rst_n    (rst_n),
      .key_event(key_event),
      .char     (char)
   );

   // bad frame pulse for the error led
   assign frame_err = frame.valid & frame.err;

   char_write_port #(
      .HEARTBEAT_DIV(HEARTBEAT_DIV)
   ) u_port (
      .CLOCK_50        (CLOCK_50),
      .rst_n           (rst_n),
      .char            (char),
      .frame_err       (frame_err),
      .avalon_write    (avalon_write),
      .avalon_writedata(avalon_writedata),
      .leds_green      (leds_green),
      .led_heartbeat   (led_heartbeat),
      .led_error       (led_error)
   );

   // jtag uart data register sits at address 0
   assign avalon_address = 1'b0;

endmodule

// ==== tb_kbd_console.sv ====
// testbench for the keyboard-to-console path
// ps/2 device model, write checker, test sequence and cycle timeout

module tb_kbd_console;
   import kbd_pkg::*;

   localparam int RX_TIMEOUT    = 200;
   localparam int HEARTBEAT_DIV = 50;
   // ps/2 half period in system cycles
   localparam int HALF_BIT      = 10;
   // idle time after each frame exceeds the pipeline latency
   localparam int FRAME_GAP     = 20;
   // upper bound on frames sent by all tests together
   localparam int FRAME_BUDGET  = 64;
   localparam int TIMEOUT_CYCLES = FRAME_BUDGET * 25 * 2 * HALF_BIT + 2000;

   // set-2 make codes for a to z and 0 to 9
   localparam logic [7:0] LETTER_CODES [26] = '{
      8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
      8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
      8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
   };
   localparam logic [7:0] DIGIT_CODES [10] = '{
      8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
   };

   logic        CLOCK_50;
   logic        rst_n;
   logic        ps2_clk;
   logic        ps2_dat;
   logic        avalon_write;
   logic        avalon_address;
   logic [31:0] avalon_writedata;
   logic [7:0]  leds_green;
   logic        led_heartbeat;
   logic        led_error;

   // expected characters with the oldest first
   logic [7:0]  exp_q [$];
   logic [7:0]  last_char;
   logic [31:0] exp_data;
   integer      seed;
   int          errors    = 0;
   int          err_mark  = 0;
   int          pass_cnt  = 0;
   int          fail_cnt  = 0;
   int          cycle_cnt = 0;

   kbd_console_top #(
      .RX_TIMEOUT   (RX_TIMEOUT),
      .HEARTBEAT_DIV(HEARTBEAT_DIV)
   ) DUT (
      .CLOCK_50        (CLOCK_50),
      .rst_n           (rst_n),
      .ps2_clk         (ps2_clk),
      .ps2_dat         (ps2_dat),
      .avalon_write    (avalon_write),
      .avalon_address  (avalon_address),
      .avalon_writedata(avalon_writedata),
      .leds_green      (leds_green),
      .led_heartbeat   (led_heartbeat),
      .led_error       (led_error)
   );

   initial begin
      CLOCK_50 = 1'b0;
      forever #2 CLOCK_50 = ~CLOCK_50;
   end

   // ====================
   // write checker
   // ====================
   // outputs are sampled on the falling edge
   always @(negedge CLOCK_50) begin
      if (rst_n && avalon_write) begin
         assert (exp_q.size() != 0) else begin
            $display("time %0t: console write of %h with no character expected",
                     $time, avalon_writedata);
            errors++;
         end
         if (exp_q.size() != 0) begin
            exp_data = {24'h000000, exp_q.pop_front()};
            assert (avalon_writedata == exp_data) else begin
               $display("mismatch time %0t avalon_writedata got %h expected %h",
                        $time, avalon_writedata, exp_data);
               errors++;
            end
         end
         assert (avalon_address == 1'b0) else begin
            $display("mismatch time %0t avalon_address got %b expected 0",
                     $time, avalon_address);
            errors++;
         end
      end
   end

   // hung run guard
   always @(posedge CLOCK_50) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ====================
   // ps/2 device model
   // ====================
   task automatic wait_cycles(input int n);
      repeat (n) @(negedge CLOCK_50);
   endtask

   // frame bits are start, data lsb first, odd parity and stop
   // nbits below 11 cuts the frame short
   task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                             input int nbits);
      logic [10:0] bits;
      int          i;
      bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
      @(negedge CLOCK_50);
      for (i = 0; i < nbits; i++) begin
         // data settles while the clock is high
         ps2_dat = bits[i];
         wait_cycles(HALF_BIT);
         ps2_clk = 1'b0;
         wait_cycles(HALF_BIT);
         ps2_clk = 1'b1;
      end
      ps2_dat = 1'b1;
      wait_cycles(FRAME_GAP);
   endtask

   task automatic send_code(input logic [7:0] code);
      send_frame(code, 1'b0, 11);
   endtask

   // F0 then the code
   task automatic release_key(input logic [7:0] code);
      send_code(SC_BREAK);
      send_code(code);
   endtask

   // the write lands during the frame gap after the code
   task automatic type_expect(input logic [7:0] code, input logic [7:0] ascii);
      exp_q.push_back(ascii);
      last_char = ascii;
      send_code(code);
   endtask

   task automatic type_letter(input logic upper);
      int         idx;
      logic [7:0] base;
      idx  = {$random(seed)} % 26;
      base = upper ? 8'h41 : 8'h61;
      type_expect(LETTER_CODES[idx], base + 8'(idx));
   endtask

   task automatic type_digit(input int d);
      type_expect(DIGIT_CODES[d], 8'h30 + 8'(d));
   endtask

   // ====================
   // test bookkeeping
   // ====================
   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch time %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic begin_test();
      err_mark = errors;
   endtask

   task automatic end_test(input string name);
      assert (exp_q.size() == 0) else begin
         $display("time %0t: %0d expected characters were never written",
                  $time, exp_q.size());
         errors++;
      end
      exp_q.delete();
      compare_value("leds_green", leds_green, last_char);
      if (errors == err_mark) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: failed with %0d errors", name, errors - err_mark);
      end
   endtask

   task automatic check_heartbeat();
      logic hb_start;
      logic seen;
      hb_start = led_heartbeat;
      seen     = 1'b0;
      repeat (2 * HEARTBEAT_DIV) begin
         @(negedge CLOCK_50);
         if (led_heartbeat != hb_start) begin
            seen = 1'b1;
         end
      end
      assert (seen) else begin
         $display("time %0t: heartbeat led did not toggle in %0d cycles",
                  $time, 2 * HEARTBEAT_DIV);
         errors++;
      end
   endtask

   // ====================
   // test sequence
   // ====================
   initial begin
      int d;
      rst_n     = 1'b0;
      ps2_clk   = 1'b1;
      ps2_dat   = 1'b1;
      seed      = 32'h4ec1;
      last_char = 8'h00;
      repeat (3) @(negedge CLOCK_50);
      rst_n = 1'b1;

      // outputs straight out of reset and the heartbeat
      begin_test();
      compare_value("avalon_write", avalon_write, 0);
      compare_value("led_error", led_error, 0);
      compare_value("leds_green", leds_green, 0);
      check_heartbeat();
      end_test("reset_heartbeat");

      // plain make codes
      begin_test();
      repeat (8) type_letter(1'b0);
      for (d = 0; d < 10; d++) begin
         type_digit(d);
      end
      type_expect(8'h29, 8'h20);
      type_expect(8'h5A, 8'h0D);
      type_expect(8'h66, 8'h08);
      end_test("make_codes");

      // releases and both shift keys
      begin_test();
      type_expect(8'h1C, 8'h61);
      release_key(8'h1C);
      send_code(SC_LSHIFT);
      repeat (3) type_letter(1'b1);
      type_digit(1);
      type_digit(7);
      release_key(SC_LSHIFT);
      send_code(SC_RSHIFT);
      repeat (2) type_letter(1'b1);
      release_key(SC_RSHIFT);
      repeat (2) type_letter(1'b0);
      end_test("break_shift");

      // extended, unmapped and lone shift keys
      // keypad enter shares 5A with the main enter key
      begin_test();
      send_code(SC_EXT);
      send_code(8'h5A);
      send_code(SC_EXT);
      release_key(8'h5A);
      send_code(8'h05);
      send_code(8'h76);
      send_code(SC_LSHIFT);
      release_key(SC_LSHIFT);
      send_code(SC_RSHIFT);
      release_key(SC_RSHIFT);
      type_letter(1'b0);
      end_test("ext_unmapped");

      // parity error sets the sticky led
      begin_test();
      compare_value("led_error", led_error, 0);
      send_frame(8'h1C, 1'b1, 11);
      compare_value("led_error", led_error, 1);
      repeat (2) type_letter(1'b0);
      compare_value("led_error", led_error, 1);
      end_test("bad_parity");

      // stalled frame dropped by the receiver timeout
      begin_test();
      send_frame(8'h1C, 1'b0, 5);
      wait_cycles(RX_TIMEOUT + 100);
      type_letter(1'b0);
      end_test("truncated");

      $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
kbd_pkg.sv
ps2_frame_rx.sv
scan_code_decoder.sv
ascii_mapper.sv
char_write_port.sv
kbd_console_top.sv
tb_kbd_console.sv

// ==== Makefile ====
# Verilator build and run for the keyboard-to-console testbench

VERILATOR ?= verilator
TOP       ?= tb_kbd_console
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
